/* src/link_macros.svh */
`ifndef LINK_MACROS_SVH
`define LINK_MACROS_SVH

// word format
`define LINK_DWIDTH 16
`define LINK_KWIDTH 2
`define LINK_COMMA_CODE 8'hBC
`define LINK_MARKER_K 2'b01 // control bits of markers and comma

// wait counts in clk cycles
`define LINK_CNT_WIDTH 16
`define LINK_WAIT_CYCLES 200
`define LINK_CPLL_RESET_CYCLES 2
`define LINK_TXRX_RESET_CYCLES 100
`define LINK_DLY_RESET_CYCLES 5
`define LINK_CDR_STABLE_CYCLES 64
`define LINK_MARKER_CYCLES 100

// timeouts, scaled down for simulation
`define LINK_TMO_SHORT 4096
`define LINK_TMO_LONG 12288

// low samples tolerated before cdr unlock
`define LINK_CDR_UNLOCK_MAX 3

`endif

/* src/link_pkg.sv */
`default_nettype none

`include "link_macros.svh"

package link_pkg;

	typedef enum logic [4:0] {
		IDLE,
		TX_WAIT,
		CPLL_RESET,
		CPLL_RESETTING,
		TXRX_RESET,
		TXRX_RESETTING,
		TX_RESET_DONE,
		RX_RESET_DONE,
		TXRX_RESET_DONE,
		TX_DLY_RESET,
		TX_DLY_WAIT,
		TX_PH_STB1,
		TX_PH_STB2,
		TX_PH_CHECK,
		RX_WAIT,
		RX_CDR_READY,
		RX_CDR_STABLE,
		RX_DLY_RESET,
		RX_DLY_WAIT,
		ALIGN1,
		ALIGN2,
		ALIGN2_CHECK,
		ALIGN3,
		DATA,
		RX_ERR,
		TX_TMO,
		RX_TMO
	} link_state_e;

	// what the tx word mux sends
	typedef enum logic [2:0] {
		MARKER1,
		MARKER2,
		MARKER3,
		USER,
		COMMA
	} tx_sel_e;

	typedef struct packed {
		logic [`LINK_DWIDTH/2-1:0] index; // marker number, 0 for a comma
		logic [`LINK_DWIDTH/2-1:0] code;
	} link_marker_t;

	typedef union packed {
		logic [`LINK_DWIDTH-1:0] raw;
		link_marker_t marker;
	} link_word_u;

endpackage

`default_nettype wire

/* src/rx_word_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module rx_word_decode (
	input wire clk,
	input wire reset,
	input wire [`LINK_DWIDTH-1:0] rx_data_i,
	input wire [`LINK_KWIDTH-1:0] rx_char_is_k_i,
	input wire [`LINK_KWIDTH-1:0] rx_disp_err_i,
	input wire [`LINK_KWIDTH-1:0] rx_not_in_table_i,
	input wire [15:0] tx_phase_i,
	input wire [4:0] tx_phase_target_i,
	input wire bypass_phase_check_i,
	output logic align1_req_o,
	output logic align2_req_o,
	output logic rx_err_o,
	output logic tx_phase_good_o
);

	link_pkg::link_word_u rx_word;
	logic marker_like; // comma code with marker control bits
	logic [16:0] phase_x5;
	logic [4:0] phase_scaled;

	assign rx_word = rx_data_i;
	assign marker_like = (rx_char_is_k_i == `LINK_MARKER_K) &&
		(rx_word.marker.code == `LINK_COMMA_CODE);

	assign align1_req_o = marker_like && (rx_word.marker.index == 8'd1);
	assign align2_req_o = marker_like && (rx_word.marker.index == 8'd2);
	assign rx_err_o = |{rx_disp_err_i, rx_not_in_table_i};

	// only the low 14 bits of the phase count matter
	assign phase_x5 = {3'b000, tx_phase_i[13:0]} * 17'd5;
	assign phase_scaled = phase_x5[16:12];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx_phase_good_o <= 1'b0;
		end else begin
			tx_phase_good_o <= bypass_phase_check_i || (phase_scaled == tx_phase_target_i);
		end
	end

endmodule

`default_nettype wire

/* src/lock_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module lock_monitor (
	input wire clk,
	input wire reset,
	input wire rx_cdr_lock_i,
	input wire tx_dly_sreset_i,
	input wire tx_dly_sreset_done_i,
	input wire tx_ph_align_done_i,
	input wire rx_dly_sreset_i,
	input wire rx_dly_sreset_done_i,
	input wire rx_ph_align_done_i,
	output logic cdr_locked_o,
	output logic tx_ph_aligned_o,
	output logic rx_ph_aligned_o
);

	localparam int UNLOCK_W = $clog2(`LINK_CDR_UNLOCK_MAX + 1);

	logic [UNLOCK_W-1:0] unlock_cnt;

	// bit 0 is the tx aligner, bit 1 the rx aligner
	logic [1:0] dly_sreset;
	logic [1:0] dly_done;
	logic [1:0] align_done;
	logic [1:0] align_done_d;
	logic [1:0] first_edge; // next rising edge is the one right after reset
	logic [1:0] aligned;

	assign dly_sreset = {rx_dly_sreset_i, tx_dly_sreset_i};
	assign dly_done = {rx_dly_sreset_done_i, tx_dly_sreset_done_i};
	assign align_done = {rx_ph_align_done_i, tx_ph_align_done_i};

	// short cdr dropouts are filtered
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			unlock_cnt <= '0;
			cdr_locked_o <= 1'b0;
		end else if (!rx_cdr_lock_i) begin
			if (unlock_cnt != UNLOCK_W'(`LINK_CDR_UNLOCK_MAX)) begin
				unlock_cnt <= unlock_cnt + 1'b1;
			end else begin
				cdr_locked_o <= 1'b0;
			end
		end else begin
			unlock_cnt <= '0;
			cdr_locked_o <= 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			align_done_d <= '0;
			first_edge <= '1;
			aligned <= '0;
		end else begin
			align_done_d <= align_done;
			for (int i = 0; i < 2; i++) begin
				if (dly_sreset[i] || dly_done[i]) begin
					first_edge[i] <= 1'b1; // re-arm
					aligned[i] <= 1'b0;
				end else if (align_done[i] && !align_done_d[i]) begin
					first_edge[i] <= 1'b0;
					if (!first_edge[i]) begin
						aligned[i] <= 1'b1;
					end
				end
			end
		end
	end

	assign tx_ph_aligned_o = aligned[0];
	assign rx_ph_aligned_o = aligned[1];

endmodule

`default_nettype wire

/* src/bringup_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module bringup_sequencer (
	input wire clk,
	input wire reset,
	input wire cpll_lock_i,
	input wire cpll_fbclk_lost_i,
	input wire cpll_refclk_lost_i,
	input wire tx_reset_done_i,
	input wire rx_reset_done_i,
	input wire rx_byte_is_aligned_i,
	input wire tx_phase_stb_i,
	input wire align1_req_i,
	input wire align2_req_i,
	input wire rx_err_i,
	input wire tx_phase_good_i,
	input wire cdr_locked_i,
	input wire tx_ph_aligned_i,
	input wire rx_ph_aligned_i,
	output logic cpll_reset_o,
	output logic gt_txrx_reset_o,
	output logic tx_dly_sreset_o,
	output logic rx_dly_sreset_o,
	output logic link_up_o,
	output logic [15:0] attempt_count_o,
	output link_pkg::link_state_e state_o,
	output link_pkg::tx_sel_e tx_sel_o
);

	link_pkg::link_state_e next;
	logic [`LINK_CNT_WIDTH-1:0] cnt; // cycles in the current state
	logic [15:0] attempt;
	logic tmo;
	logic tmo_long;
	logic pll_fault;
	logic far_end_aligned;

	assign tmo = cnt == `LINK_TMO_SHORT;
	assign tmo_long = cnt == `LINK_TMO_LONG;
	assign pll_fault = !cpll_lock_i || cpll_fbclk_lost_i || cpll_refclk_lost_i;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_o <= link_pkg::IDLE;
			cnt <= '0;
		end else begin
			state_o <= next;
			cnt <= (state_o == next) ? cnt + 1'b1 : '0;
		end
	end

	always_comb begin
		next = link_pkg::TX_WAIT;
		case (state_o)
			link_pkg::IDLE: next = link_pkg::TX_WAIT;
			link_pkg::TX_WAIT:
				next = tmo ? link_pkg::TX_TMO :
					(cnt == `LINK_WAIT_CYCLES) ? link_pkg::CPLL_RESET : link_pkg::TX_WAIT;
			link_pkg::CPLL_RESET:
				next = tmo ? link_pkg::TX_TMO :
					(cnt == `LINK_CPLL_RESET_CYCLES) ? link_pkg::CPLL_RESETTING :
					link_pkg::CPLL_RESET;
			link_pkg::CPLL_RESETTING:
				next = tmo ? link_pkg::TX_TMO :
					cpll_lock_i ? link_pkg::TXRX_RESET : link_pkg::CPLL_RESETTING;
			link_pkg::TXRX_RESET:
				next = tmo ? link_pkg::TX_TMO :
					(cnt == `LINK_TXRX_RESET_CYCLES) ? link_pkg::TXRX_RESETTING :
					link_pkg::TXRX_RESET;
			link_pkg::TXRX_RESETTING:
				next = tmo_long ? link_pkg::TX_TMO :
					tx_reset_done_i ? link_pkg::TX_RESET_DONE :
					rx_reset_done_i ? link_pkg::RX_RESET_DONE : link_pkg::TXRX_RESETTING;
			link_pkg::TX_RESET_DONE:
				next = tmo ? link_pkg::TX_TMO : pll_fault ? link_pkg::TX_WAIT :
					rx_reset_done_i ? link_pkg::TXRX_RESET_DONE : link_pkg::TX_RESET_DONE;
			link_pkg::RX_RESET_DONE:
				next = tmo ? link_pkg::TX_TMO : pll_fault ? link_pkg::TX_WAIT :
					tx_reset_done_i ? link_pkg::TXRX_RESET_DONE : link_pkg::RX_RESET_DONE;
			link_pkg::TXRX_RESET_DONE:
				next = tmo_long ? link_pkg::RX_TMO :
					(tx_reset_done_i && rx_reset_done_i && !pll_fault) ?
					link_pkg::TX_DLY_RESET : link_pkg::TX_WAIT;
			link_pkg::TX_DLY_RESET:
				next = (cnt == `LINK_DLY_RESET_CYCLES) ? link_pkg::TX_DLY_WAIT :
					link_pkg::TX_DLY_RESET;
			link_pkg::TX_DLY_WAIT:
				next = tmo ? link_pkg::TX_TMO :
					tx_ph_aligned_i ? link_pkg::TX_PH_STB1 : link_pkg::TX_DLY_WAIT;
			// two strobes so the phase sample is fresh
			link_pkg::TX_PH_STB1:
				next = tx_phase_stb_i ? link_pkg::TX_PH_STB2 : link_pkg::TX_PH_STB1;
			link_pkg::TX_PH_STB2:
				next = tx_phase_stb_i ? link_pkg::TX_PH_CHECK : link_pkg::TX_PH_STB2;
			link_pkg::TX_PH_CHECK:
				next = tx_phase_good_i ? link_pkg::RX_WAIT : link_pkg::TX_WAIT;
			link_pkg::RX_WAIT:
				next = !tx_phase_good_i ? link_pkg::TX_WAIT :
					(cnt == `LINK_WAIT_CYCLES) ? link_pkg::RX_CDR_READY : link_pkg::RX_WAIT;
			link_pkg::RX_CDR_READY:
				next = !tx_phase_good_i ? link_pkg::TX_WAIT :
					cdr_locked_i ? link_pkg::RX_CDR_STABLE : link_pkg::RX_CDR_READY;
			link_pkg::RX_CDR_STABLE:
				next = !tx_phase_good_i ? link_pkg::TX_WAIT :
					!cdr_locked_i ? link_pkg::RX_CDR_READY :
					(cnt == `LINK_CDR_STABLE_CYCLES) ? link_pkg::RX_DLY_RESET :
					link_pkg::RX_CDR_STABLE;
			link_pkg::RX_DLY_RESET:
				next = tmo ? link_pkg::RX_TMO : !tx_phase_good_i ? link_pkg::TX_WAIT :
					(cnt == `LINK_DLY_RESET_CYCLES) ? link_pkg::RX_DLY_WAIT :
					link_pkg::RX_DLY_RESET;
			link_pkg::RX_DLY_WAIT:
				next = tmo ? link_pkg::RX_TMO :
					rx_ph_aligned_i ? link_pkg::ALIGN1 : link_pkg::RX_DLY_WAIT;
			link_pkg::ALIGN1:
				next = tmo ? link_pkg::RX_TMO : !cdr_locked_i ? link_pkg::RX_WAIT :
					rx_byte_is_aligned_i ? link_pkg::ALIGN2 : link_pkg::ALIGN1;
			link_pkg::ALIGN2:
				next = tmo ? link_pkg::RX_TMO : !cdr_locked_i ? link_pkg::RX_WAIT :
					!rx_byte_is_aligned_i ? link_pkg::ALIGN1 :
					(cnt == `LINK_MARKER_CYCLES) ? link_pkg::ALIGN2_CHECK : link_pkg::ALIGN2;
			link_pkg::ALIGN2_CHECK:
				next = tmo ? link_pkg::RX_TMO : !cdr_locked_i ? link_pkg::RX_WAIT :
					!rx_byte_is_aligned_i ? link_pkg::ALIGN1 :
					far_end_aligned ? link_pkg::ALIGN3 : link_pkg::ALIGN2;
			link_pkg::ALIGN3:
				next = tmo ? link_pkg::RX_TMO : !cdr_locked_i ? link_pkg::RX_WAIT :
					!rx_byte_is_aligned_i ? link_pkg::ALIGN1 :
					(cnt == `LINK_MARKER_CYCLES) ? link_pkg::DATA : link_pkg::ALIGN3;
			link_pkg::DATA:
				next = (pll_fault || !tx_phase_good_i) ? link_pkg::TX_WAIT :
					!cdr_locked_i ? link_pkg::RX_WAIT :
					rx_err_i ? link_pkg::RX_ERR :
					!rx_byte_is_aligned_i ? link_pkg::ALIGN1 :
					align1_req_i ? link_pkg::ALIGN2 : // far end restarted
					align2_req_i ? link_pkg::ALIGN3 :
					link_pkg::DATA;
			link_pkg::RX_ERR: next = link_pkg::ALIGN1;
			link_pkg::TX_TMO: next = link_pkg::TX_WAIT;
			link_pkg::RX_TMO: next = link_pkg::TX_WAIT;
			default: next = link_pkg::TX_WAIT;
		endcase
	end

	// outputs follow the next state so they line up with it
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cpll_reset_o <= 1'b0;
			gt_txrx_reset_o <= 1'b0;
			tx_dly_sreset_o <= 1'b0;
			rx_dly_sreset_o <= 1'b0;
			link_up_o <= 1'b0;
			far_end_aligned <= 1'b0;
			attempt <= '0;
			attempt_count_o <= '0;
			tx_sel_o <= link_pkg::MARKER1;
		end else begin
			case (next)
				link_pkg::TX_WAIT: begin
					cpll_reset_o <= 1'b1;
					gt_txrx_reset_o <= 1'b1;
					tx_dly_sreset_o <= 1'b0;
					rx_dly_sreset_o <= 1'b0;
					link_up_o <= 1'b0;
					tx_sel_o <= link_pkg::COMMA;
				end
				link_pkg::CPLL_RESET: begin
					cpll_reset_o <= 1'b1;
					gt_txrx_reset_o <= 1'b1;
					link_up_o <= 1'b0;
					if (state_o != link_pkg::CPLL_RESET) begin
						attempt <= attempt + 1'b1; // count each try once
					end
				end
				link_pkg::CPLL_RESETTING: begin
					cpll_reset_o <= 1'b0;
					gt_txrx_reset_o <= 1'b0;
				end
				link_pkg::TXRX_RESET: gt_txrx_reset_o <= 1'b1;
				link_pkg::TXRX_RESETTING, link_pkg::TX_RESET_DONE, link_pkg::RX_RESET_DONE:
					gt_txrx_reset_o <= 1'b0;
				link_pkg::TXRX_RESET_DONE: begin
					gt_txrx_reset_o <= 1'b0;
					link_up_o <= 1'b1;
				end
				link_pkg::TX_DLY_RESET: begin
					tx_dly_sreset_o <= 1'b1;
					far_end_aligned <= 1'b0;
				end
				link_pkg::TX_DLY_WAIT: tx_dly_sreset_o <= 1'b0;
				link_pkg::RX_WAIT: tx_sel_o <= link_pkg::MARKER1;
				link_pkg::RX_DLY_RESET: rx_dly_sreset_o <= 1'b1;
				link_pkg::RX_DLY_WAIT: rx_dly_sreset_o <= 1'b0;
				link_pkg::ALIGN1: begin
					if (align2_req_i) begin
						far_end_aligned <= 1'b1;
					end
					tx_sel_o <= link_pkg::MARKER1;
				end
				link_pkg::ALIGN2, link_pkg::ALIGN2_CHECK: begin
					if (align2_req_i) begin
						far_end_aligned <= 1'b1;
					end
					tx_sel_o <= link_pkg::MARKER2;
				end
				link_pkg::ALIGN3: tx_sel_o <= link_pkg::MARKER3;
				link_pkg::DATA: begin
					// keep the last nonzero count across realigns
					if (attempt != '0) begin
						attempt_count_o <= attempt;
						attempt <= '0;
					end
					link_up_o <= 1'b1;
					far_end_aligned <= 1'b0;
					tx_sel_o <= link_pkg::USER;
				end
				link_pkg::RX_ERR: link_up_o <= 1'b0;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/tx_word_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module tx_word_mux (
	input wire clk,
	input wire reset,
	input link_pkg::tx_sel_e tx_sel_i,
	input wire [`LINK_DWIDTH-1:0] tx_data_i,
	input wire [`LINK_KWIDTH-1:0] tx_char_is_k_i,
	output logic [`LINK_DWIDTH-1:0] tx_data_o,
	output logic [`LINK_KWIDTH-1:0] tx_char_is_k_o
);

	link_pkg::link_word_u marker_word;

	always_comb begin
		marker_word.marker.code = `LINK_COMMA_CODE;
		case (tx_sel_i)
			link_pkg::MARKER1: marker_word.marker.index = 8'd1;
			link_pkg::MARKER2: marker_word.marker.index = 8'd2;
			link_pkg::MARKER3: marker_word.marker.index = 8'd3;
			default: marker_word.marker.index = 8'd0; // comma
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx_data_o <= {8'd1, `LINK_COMMA_CODE}; // marker 1
			tx_char_is_k_o <= `LINK_MARKER_K;
		end else if (tx_sel_i == link_pkg::USER) begin
			tx_data_o <= tx_data_i;
			tx_char_is_k_o <= tx_char_is_k_i;
		end else begin
			tx_data_o <= marker_word.raw;
			tx_char_is_k_o <= `LINK_MARKER_K;
		end
	end

endmodule

`default_nettype wire

/* src/link_bringup_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module link_bringup_top (
	input wire clk,
	input wire reset,
	// transceiver status
	input wire cpll_lock_i,
	input wire cpll_fbclk_lost_i,
	input wire cpll_refclk_lost_i,
	input wire tx_reset_done_i,
	input wire rx_reset_done_i,
	input wire rx_byte_is_aligned_i,
	input wire rx_cdr_lock_i,
	input wire tx_dly_sreset_done_i,
	input wire tx_ph_align_done_i,
	input wire rx_dly_sreset_done_i,
	input wire rx_ph_align_done_i,
	// received word
	input wire [`LINK_DWIDTH-1:0] rx_data_i,
	input wire [`LINK_KWIDTH-1:0] rx_char_is_k_i,
	input wire [`LINK_KWIDTH-1:0] rx_disp_err_i,
	input wire [`LINK_KWIDTH-1:0] rx_not_in_table_i,
	// tx phase measurement
	input wire [15:0] tx_phase_i,
	input wire tx_phase_stb_i,
	input wire [4:0] tx_phase_target_i,
	input wire bypass_phase_check_i,
	// user word
	input wire [`LINK_DWIDTH-1:0] tx_data_i,
	input wire [`LINK_KWIDTH-1:0] tx_char_is_k_i,
	output logic cpll_reset_o,
	output logic gt_txrx_reset_o,
	output logic tx_dly_sreset_o,
	output logic rx_dly_sreset_o,
	output logic [`LINK_DWIDTH-1:0] tx_data_o,
	output logic [`LINK_KWIDTH-1:0] tx_char_is_k_o,
	output logic link_up_o,
	output logic [15:0] attempt_count_o,
	output link_pkg::link_state_e state_o
);

	logic align1_req;
	logic align2_req;
	logic rx_err;
	logic tx_phase_good;
	logic cdr_locked;
	logic tx_ph_aligned;
	logic rx_ph_aligned;
	link_pkg::tx_sel_e tx_sel;

	rx_word_decode u_rx_word_decode (
		.clk(clk),
		.reset(reset),
		.rx_data_i(rx_data_i),
		.rx_char_is_k_i(rx_char_is_k_i),
		.rx_disp_err_i(rx_disp_err_i),
		.rx_not_in_table_i(rx_not_in_table_i),
		.tx_phase_i(tx_phase_i),
		.tx_phase_target_i(tx_phase_target_i),
		.bypass_phase_check_i(bypass_phase_check_i),
		.align1_req_o(align1_req),
		.align2_req_o(align2_req),
		.rx_err_o(rx_err),
		.tx_phase_good_o(tx_phase_good)
	);

	// delay resets come back from the sequencer to re-arm the qualifiers
	lock_monitor u_lock_monitor (
		.clk(clk),
		.reset(reset),
		.rx_cdr_lock_i(rx_cdr_lock_i),
		.tx_dly_sreset_i(tx_dly_sreset_o),
		.tx_dly_sreset_done_i(tx_dly_sreset_done_i),
		.tx_ph_align_done_i(tx_ph_align_done_i),
		.rx_dly_sreset_i(rx_dly_sreset_o),
		.rx_dly_sreset_done_i(rx_dly_sreset_done_i),
		.rx_ph_align_done_i(rx_ph_align_done_i),
		.cdr_locked_o(cdr_locked),
		.tx_ph_aligned_o(tx_ph_aligned),
		.rx_ph_aligned_o(rx_ph_aligned)
	);

	bringup_sequencer u_bringup_sequencer (
		.clk(clk),
		.reset(reset),
		.cpll_lock_i(cpll_lock_i),
		.cpll_fbclk_lost_i(cpll_fbclk_lost_i),
		.cpll_refclk_lost_i(cpll_refclk_lost_i),
		.tx_reset_done_i(tx_reset_done_i),
		.rx_reset_done_i(rx_reset_done_i),
		.rx_byte_is_aligned_i(rx_byte_is_aligned_i),
		.tx_phase_stb_i(tx_phase_stb_i),
		.align1_req_i(align1_req),
		.align2_req_i(align2_req),
		.rx_err_i(rx_err),
		.tx_phase_good_i(tx_phase_good),
		.cdr_locked_i(cdr_locked),
		.tx_ph_aligned_i(tx_ph_aligned),
		.rx_ph_aligned_i(rx_ph_aligned),
		.cpll_reset_o(cpll_reset_o),
		.gt_txrx_reset_o(gt_txrx_reset_o),
		.tx_dly_sreset_o(tx_dly_sreset_o),
		.rx_dly_sreset_o(rx_dly_sreset_o),
		.link_up_o(link_up_o),
		.attempt_count_o(attempt_count_o),
		.state_o(state_o),
		.tx_sel_o(tx_sel)
	);

	tx_word_mux u_tx_word_mux (
		.clk(clk),
		.reset(reset),
		.tx_sel_i(tx_sel),
		.tx_data_i(tx_data_i),
		.tx_char_is_k_i(tx_char_is_k_i),
		.tx_data_o(tx_data_o),
		.tx_char_is_k_o(tx_char_is_k_o)
	);

endmodule

`default_nettype wire

/* tb/link_bringup_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

// delay aligner model that pulses reset-done and then align-done twice
module aligner_model (
	input wire clk,
	input wire reset,
	input wire dly_sreset_i,
	output logic sreset_done_o,
	output logic align_done_o
);

	int step;
	logic busy;

	initial begin
		step = 0;
		busy = 1'b0;
		sreset_done_o = 1'b0;
		align_done_o = 1'b0;
		forever begin
			@(negedge clk);
			if (reset) begin
				busy = 1'b0;
				sreset_done_o = 1'b0;
				align_done_o = 1'b0;
			end else if (dly_sreset_i) begin
				busy = 1'b1; // sequence starts once the reset drops
				step = 0;
				sreset_done_o = 1'b0;
				align_done_o = 1'b0;
			end else if (busy) begin
				step = step + 1;
				sreset_done_o = (step == 3);
				align_done_o = (step == 8) || (step == 14);
				if (step == 15) begin
					busy = 1'b0;
				end
			end
		end
	end

endmodule

module link_bringup_tb;

	localparam logic [15:0] PHASE = 16'h1A3C;
	localparam logic [1:0] MARKER_K = 2'b01;
	localparam int CPLL_LOCK_DELAY = 4;
	localparam int RESET_DONE_DELAY = 10;
	localparam int STB_PERIOD = 16;
	localparam int BRINGUP_LIMIT = 20000;
	localparam int USER_CHECKS = 64;

	logic clk;
	logic reset;
	logic cpll_lock;
	logic cpll_fbclk_lost;
	logic cpll_refclk_lost;
	logic tx_reset_done;
	logic rx_reset_done;
	logic byte_aligned;
	logic rx_cdr_lock;
	logic tx_dly_done;
	logic tx_align_done;
	logic rx_dly_done;
	logic rx_align_done;
	logic [15:0] rx_data;
	logic [1:0] rx_k;
	logic [1:0] rx_disp_err;
	logic [1:0] rx_not_in_table;
	logic [15:0] tx_phase;
	logic tx_phase_stb;
	logic [4:0] tx_phase_target;
	logic bypass;
	logic [15:0] user_data;
	logic [1:0] user_k;
	logic cpll_reset;
	logic gt_txrx_reset;
	logic tx_dly_sreset;
	logic rx_dly_sreset;
	logic [15:0] tx_data;
	logic [1:0] tx_k;
	logic link_up;
	logic [15:0] attempt_count;
	link_pkg::link_state_e state;

	logic hold_cpll_lock = 1'b0; // withholds pll lock for the timeout test
	logic [15:0] applied_user = '0;
	logic [1:0] applied_k = '0;
	int marker_phase = 0; // 1 to 3 for marker n on the wire and 4 for user data
	int user_checked = 0;
	logic markers_done = 1'b0;
	logic [4:0] good_target;
	logic [4:0] bad_target;

	link_bringup_top uut (
		.clk(clk),
		.reset(reset),
		.cpll_lock_i(cpll_lock),
		.cpll_fbclk_lost_i(cpll_fbclk_lost),
		.cpll_refclk_lost_i(cpll_refclk_lost),
		.tx_reset_done_i(tx_reset_done),
		.rx_reset_done_i(rx_reset_done),
		.rx_byte_is_aligned_i(byte_aligned),
		.rx_cdr_lock_i(rx_cdr_lock),
		.tx_dly_sreset_done_i(tx_dly_done),
		.tx_ph_align_done_i(tx_align_done),
		.rx_dly_sreset_done_i(rx_dly_done),
		.rx_ph_align_done_i(rx_align_done),
		.rx_data_i(rx_data),
		.rx_char_is_k_i(rx_k),
		.rx_disp_err_i(rx_disp_err),
		.rx_not_in_table_i(rx_not_in_table),
		.tx_phase_i(tx_phase),
		.tx_phase_stb_i(tx_phase_stb),
		.tx_phase_target_i(tx_phase_target),
		.bypass_phase_check_i(bypass),
		.tx_data_i(user_data),
		.tx_char_is_k_i(user_k),
		.cpll_reset_o(cpll_reset),
		.gt_txrx_reset_o(gt_txrx_reset),
		.tx_dly_sreset_o(tx_dly_sreset),
		.rx_dly_sreset_o(rx_dly_sreset),
		.tx_data_o(tx_data),
		.tx_char_is_k_o(tx_k),
		.link_up_o(link_up),
		.attempt_count_o(attempt_count),
		.state_o(state)
	);

	aligner_model tx_aligner (
		.clk(clk),
		.reset(reset),
		.dly_sreset_i(tx_dly_sreset),
		.sreset_done_o(tx_dly_done),
		.align_done_o(tx_align_done)
	);

	aligner_model rx_aligner (
		.clk(clk),
		.reset(reset),
		.dly_sreset_i(rx_dly_sreset),
		.sreset_done_o(rx_dly_done),
		.align_done_o(rx_align_done)
	);

	// low 14 bits of the phase times 5 in units of 4096
	function automatic logic [4:0] scaled_phase(input logic [15:0] phase);
		int p;
		p = int'(phase[13:0]);
		p = (p * 5) / 4096;
		scaled_phase = p[4:0];
	endfunction

	function automatic logic phase_verdict(input logic [15:0] phase, input logic [4:0] target,
			input logic bypass_check);
		phase_verdict = bypass_check || (scaled_phase(phase) == target);
	endfunction

	function automatic logic [4:0] find_target(input logic [15:0] phase, input logic want);
		logic found;
		found = 1'b0;
		find_target = 5'd0;
		for (int i = 0; i < 32; i++) begin
			if (!found && phase_verdict(phase, 5'(i), 1'b0) == want) begin
				find_target = 5'(i);
				found = 1'b1;
			end
		end
	endfunction

	// marker n carries index n in the upper byte and the comma code below
	function automatic link_pkg::link_word_u marker_word(input logic [7:0] n);
		link_pkg::link_word_u w;
		w.marker.index = n;
		w.marker.code = `LINK_COMMA_CODE;
		marker_word = w;
	endfunction

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic stop_on_error();
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input link_pkg::link_word_u exp,
			input logic [1:0] exp_k, input link_pkg::link_word_u act, input logic [1:0] act_k);
		if (act.raw !== exp.raw || act_k !== exp_k) begin
			$display("Mismatch in %s: expected %h k %b, actual %h k %b",
				name, exp.raw, exp_k, act.raw, act_k);
			stop_on_error();
		end
	endtask

	task automatic check_count(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Mismatch in %s: expected %b, actual %b", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic wait_for_state(input link_pkg::link_state_e s, input int limit,
			input string what);
		int n;
		n = 0;
		while (state != s && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (state != s) begin
			$display("timed out after %0d cycles waiting for %s", limit, what);
			stop_on_error();
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// transceiver status, loopback and phase strobes
	initial begin : xcvr_model
		int lock_wait;
		int done_wait;
		int stb_cnt;
		lock_wait = 0;
		done_wait = 0;
		stb_cnt = 0;
		cpll_lock = 1'b0;
		tx_reset_done = 1'b0;
		rx_reset_done = 1'b0;
		rx_data = '0;
		rx_k = '0;
		tx_phase_stb = 1'b0;
		forever begin
			@(negedge clk);
			if (cpll_reset || hold_cpll_lock) begin
				lock_wait = 0;
				cpll_lock = 1'b0;
			end else if (lock_wait < CPLL_LOCK_DELAY) begin
				lock_wait++;
			end else begin
				cpll_lock = 1'b1;
			end
			if (gt_txrx_reset) begin
				done_wait = 0;
				tx_reset_done = 1'b0;
				rx_reset_done = 1'b0;
			end else if (done_wait < RESET_DONE_DELAY) begin
				done_wait++;
			end else begin
				tx_reset_done = 1'b1;
				rx_reset_done = 1'b1;
			end
			rx_data = tx_data; // far end echoes our word
			rx_k = tx_k;
			stb_cnt = (stb_cnt + 1) % STB_PERIOD;
			tx_phase_stb = (stb_cnt == 0);
		end
	end

	initial begin : user_stim
		logic [15:0] lfsr;
		logic [15:0] word;
		lfsr = 16'd11454;
		word = '0;
		user_data = '0;
		user_k = 2'b00; // plain data and never a marker
		forever begin
			@(negedge clk);
			for (int b = 0; b < 16; b++) begin
				word[b] = lfsr[0];
				lfsr = lfsr_step(lfsr);
			end
			user_data = word;
		end
	end

	always @(posedge clk) begin
		applied_user <= user_data;
		applied_k <= user_k;
	end

	// marker order from ALIGN1 on, then user data
	always @(negedge clk) begin : marker_monitor
		link_pkg::link_word_u seen;
		seen = tx_data;
		if (!reset && !markers_done) begin
			if (marker_phase == 0) begin
				if (state == link_pkg::ALIGN1) begin
					check_word("align1 entry word", marker_word(8'd1), MARKER_K, seen, tx_k);
					marker_phase <= 1;
				end
			end else if (marker_phase < 3) begin
				if (seen != marker_word(8'(marker_phase)) || tx_k != MARKER_K) begin
					check_word("marker order", marker_word(8'(marker_phase + 1)), MARKER_K,
						seen, tx_k);
					marker_phase <= marker_phase + 1;
				end
			end else if (marker_phase == 4 || seen != marker_word(8'd3) ||
					tx_k != MARKER_K) begin
				check_word("user data", applied_user, applied_k, seen, tx_k);
				marker_phase <= 4;
				user_checked <= user_checked + 1;
				if (user_checked == USER_CHECKS - 1) begin
					markers_done <= 1'b1;
				end
			end
		end
	end

	initial begin : main
		int n;
		reset = 1'b1;
		cpll_fbclk_lost = 1'b0;
		cpll_refclk_lost = 1'b0;
		byte_aligned = 1'b1;
		rx_cdr_lock = 1'b1;
		rx_disp_err = 2'b00;
		rx_not_in_table = 2'b00;
		tx_phase = PHASE;
		bypass = 1'b0;
		good_target = find_target(PHASE, 1'b1);
		bad_target = find_target(PHASE, 1'b0);
		tx_phase_target = good_target;

		repeat (8) @(negedge clk);
		check_bit("reset cpll_reset_o", 1'b0, cpll_reset);
		check_bit("reset gt_txrx_reset_o", 1'b0, gt_txrx_reset);
		check_bit("reset tx_dly_sreset_o", 1'b0, tx_dly_sreset);
		check_bit("reset rx_dly_sreset_o", 1'b0, rx_dly_sreset);
		check_bit("reset link_up_o", 1'b0, link_up);
		check_count("reset attempt count", 16'd0, attempt_count);
		check_word("reset tx word", marker_word(8'd1), MARKER_K, tx_data, tx_k);
		reset = 1'b0;

		wait_for_state(link_pkg::DATA, BRINGUP_LIMIT, "first link up");
		check_bit("bring-up link_up_o", 1'b1, link_up);
		check_count("bring-up attempt count", 16'd1, attempt_count);

		n = 0;
		while (!markers_done && n < 4 * USER_CHECKS) begin
			@(negedge clk);
			n++;
		end
		if (!markers_done) begin
			$display("marker monitor never saw %0d user words", USER_CHECKS);
			stop_on_error();
		end

		// phase mismatch forces a new attempt
		tx_phase_target = bad_target;
		wait_for_state(link_pkg::TX_PH_CHECK, BRINGUP_LIMIT, "phase check with bad target");
		n = 0;
		while (!cpll_reset && n < 4) begin
			@(negedge clk);
			n++;
		end
		check_bit("phase mismatch cpll_reset_o", 1'b1, cpll_reset);
		bypass = 1'b1;
		wait_for_state(link_pkg::DATA, BRINGUP_LIMIT, "link up with bypass");
		check_bit("bypass link_up_o", 1'b1, link_up);
		check_count("bypass attempt count", 16'd2, attempt_count);

		rx_disp_err = 2'b01; // one disparity error
		@(negedge clk);
		rx_disp_err = 2'b00;
		n = 0;
		while (link_up && n < 4) begin
			@(negedge clk);
			n++;
		end
		check_bit("rx error link_up_o", 1'b0, link_up);
		wait_for_state(link_pkg::ALIGN1, 8, "realign after rx error");
		@(negedge clk);
		check_word("rx error tx word", marker_word(8'd1), MARKER_K, tx_data, tx_k);
		wait_for_state(link_pkg::DATA, BRINGUP_LIMIT, "link up after rx error");
		check_bit("relink link_up_o", 1'b1, link_up);

		hold_cpll_lock <= 1'b1;
		wait_for_state(link_pkg::CPLL_RESETTING, 600, "pll reset without lock");
		n = 0;
		while (!cpll_reset && n < `LINK_TMO_SHORT + 16) begin
			@(negedge clk);
			n++;
		end
		if (!cpll_reset) begin
			$display("cpll_reset_o stayed low for %0d cycles with the PLL unlocked", n);
			stop_on_error();
		end else if (n < `LINK_TMO_SHORT) begin
			$display("cpll_reset_o rose after %0d cycles, before the timeout", n);
			stop_on_error();
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/link_pkg.sv
src/rx_word_decode.sv
src/lock_monitor.sv
src/bringup_sequencer.sv
src/tx_word_mux.sv
src/link_bringup_top.sv
tb/link_bringup_tb.sv

/* run.sh */
#!/bin/sh
# build and run the link bring-up testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module link_bringup_tb -f all.f -o link_bringup_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/link_bringup_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx 'PASS: all tests'; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
